// File: eth_rx.f
+incdir+include
hw/eth_rx_pkg.sv
hw/eth_crc.sv
hw/eth_rx.sv
hw/eth_rx_buffer.sv
hw/eth_rx_status.sv
hw/eth_rx_top.sv
testbench/eth_rx_tb.sv

// File: hw/eth_crc.sv
`timescale 1ns/1ps

module eth_crc
   import eth_rx_pkg::*;
(
   input  logic      RX_CLK,
   input  logic      rx_rst,
   input  logic      restart,
   input  logic      data_en,
   input  eth_byte_t data_in,
   output eth_crc_t  crc_value
);

   // reflected form of 04C11DB7
   localparam eth_crc_t crc_poly = 32'hEDB88320;

   eth_crc_t crc_next;

   // lsb of the byte goes in first
   function automatic eth_crc_t crc_fold(input eth_crc_t crc, input eth_byte_t data);
      eth_crc_t c;
      int       i;
      c = crc;
      for (i = 0; i < 8; i++) begin
         if (c[0] ^ data[i]) begin
            c = (c >> 1) ^ crc_poly;
         end else begin
            c = c >> 1;
         end
      end
      return c;
   endfunction

   always_comb begin
      crc_next = crc_fold(crc_value, data_in);
   end

   // no final inversion, the status block checks the residue
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         crc_value <= '1;
      end else if (restart) begin
         crc_value <= '1;
      end else if (data_en) begin
         crc_value <= crc_next;
      end
   end

endmodule

// File: hw/eth_rx.sv
`timescale 1ns/1ps

`include "eth_rx_config.svh"

module eth_rx
   import eth_rx_pkg::*;
(
   input  logic          RX_CLK,
   input  logic          rx_rst,
   input  logic          rx_dv,
   input  logic [3:0]    rx_data,
   input  logic          frame_ack,
   output logic          frame_ready,
   output logic          byte_wr,
   output eth_buf_addr_t wr_addr,
   output eth_byte_t     wr_data,
   output eth_crc_t      crc_value
);

   localparam eth_buf_addr_t last_addr_byte = eth_buf_addr_t'(`ETH_MAC_ADDR_LEN - 1);

   logic [1:0]                      rst_pipe;
   logic                            rst_sync;
   eth_rx_state_t                   state;
   eth_byte_t                       rx_byte;
   eth_byte_t                       nib_byte;
   logic [8*`ETH_MAC_ADDR_LEN-1:0]  dest_addr;
   logic                            crc_restart;

   // reset sync, released two edges after rx_rst falls
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         rst_pipe <= 2'b11;
      end else begin
         rst_pipe <= {rst_pipe[0], 1'b0};
      end
   end

   assign rst_sync = rst_pipe[1];

   // new nibble lands above the previous one
   assign nib_byte = {rx_data, rx_byte[7:4]};

   always_ff @(posedge RX_CLK or posedge rst_sync) begin
      if (rst_sync) begin
         rx_byte <= '0;
      end else if (rx_dv) begin
         rx_byte <= nib_byte;
      end
   end

   // the byte register holds a complete byte in every write cycle
   assign wr_data = rx_byte;

   // destination address, first byte ends up on top
   always_ff @(posedge RX_CLK) begin
      if (state == rx_addr_byte && rx_dv) begin
         dest_addr <= {dest_addr[8*`ETH_MAC_ADDR_LEN-9:0], nib_byte};
      end
   end

   always_ff @(posedge RX_CLK or posedge rst_sync) begin
      if (rst_sync) begin
         state       <= rx_hunt;
         wr_addr     <= '0;
         byte_wr     <= 1'b0;
         frame_ready <= 1'b0;
      end else begin
         byte_wr <= 1'b0;

         case (state)
            rx_hunt: begin
               if (rx_dv && nib_byte == `ETH_SFD) begin
                  state <= rx_addr_start;
               end
            end

            rx_addr_start: begin
               wr_addr <= '0;
               state   <= rx_dv ? rx_addr_byte : rx_hunt;
            end

            rx_addr_byte: begin
               if (rx_dv) begin
                  byte_wr <= 1'b1;
                  state   <= rx_addr_check;
               end else begin
                  state <= rx_hunt;
               end
            end

            // byte_wr is high here, address moves on after the write
            rx_addr_check: begin
               wr_addr <= wr_addr + 1'b1;
               if (wr_addr != last_addr_byte) begin
                  state <= rx_addr_byte;
               end else if (dest_addr != `ETH_MAC_ADDR) begin
                  state <= rx_drop_wait;
               end else begin
                  state <= rx_data_byte;
               end
            end

            rx_data_byte: begin
               if (rx_dv) begin
                  byte_wr <= 1'b1;
                  state   <= rx_data_next;
               end else begin
                  state <= rx_hunt;
               end
            end

            // low nibble of the next byte, or end of frame
            rx_data_next: begin
               wr_addr <= wr_addr + 1'b1;
               if (rx_dv) begin
                  state <= rx_data_byte;
               end else begin
                  frame_ready <= 1'b1;
                  state       <= rx_frame_hold;
               end
            end

            // line ignored until the host is done
            rx_frame_hold: begin
               if (frame_ack) begin
                  frame_ready <= 1'b0;
                  state       <= rx_dv ? rx_drop_wait : rx_hunt;
               end
            end

            rx_drop_wait: begin
               if (!rx_dv) begin
                  state <= rx_hunt;
               end
            end

            default: begin
               state <= rx_hunt;
            end
         endcase
      end
   end

   assign crc_restart = (state == rx_hunt);

   eth_crc crc0 (
      .RX_CLK    (RX_CLK),
      .rx_rst    (rst_sync),
      .restart   (crc_restart),
      .data_en   (byte_wr),
      .data_in   (rx_byte),
      .crc_value (crc_value)
   );

   // buffer belongs to the host while the frame is reported
   a_no_wr_while_ready: assert property (
      @(posedge RX_CLK) disable iff (rst_sync)
      !(byte_wr && frame_ready)
   );

   // past the address bytes a zero address means the buffer wrapped
   a_no_addr_wrap: assert property (
      @(posedge RX_CLK) disable iff (rst_sync)
      (state inside {rx_data_byte, rx_data_next}) |-> (wr_addr != '0)
   );

endmodule

// File: hw/eth_rx_buffer.sv
`timescale 1ns/1ps

`include "eth_rx_config.svh"

module eth_rx_buffer
   import eth_rx_pkg::*;
(
   input  logic          RX_CLK,
   input  logic          byte_wr,
   input  eth_buf_addr_t wr_addr,
   input  eth_byte_t     wr_data,
   input  eth_buf_addr_t rd_addr,
   output eth_byte_t     rd_data
);

   // one frame, destination address at byte 0
   eth_byte_t mem [`ETH_RX_BUF_DEPTH];

   always_ff @(posedge RX_CLK) begin
      if (byte_wr) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // host side, data one clock after the address
   always_ff @(posedge RX_CLK) begin
      rd_data <= mem[rd_addr];
   end

   // receiver address must be settled when it writes
   a_wr_addr_known: assert property (
      @(posedge RX_CLK)
      byte_wr |-> !$isunknown(wr_addr)
   );

endmodule

// File: hw/eth_rx_pkg.sv
`include "eth_rx_config.svh"

package eth_rx_pkg;

   // one octet from the line or the buffer
   typedef logic [7:0] eth_byte_t;

   // byte address into the frame buffer
   typedef logic [`ETH_RX_BUF_AW-1:0] eth_buf_addr_t;

   // running crc register
   typedef logic [31:0] eth_crc_t;

   // receiver states
   typedef enum logic [2:0] {
      rx_hunt,
      rx_addr_start,
      rx_addr_byte,
      rx_addr_check,
      rx_data_byte,
      rx_data_next,
      rx_frame_hold,
      rx_drop_wait
   } eth_rx_state_t;

endpackage

// File: hw/eth_rx_status.sv
`timescale 1ns/1ps

`include "eth_rx_config.svh"

module eth_rx_status
   import eth_rx_pkg::*;
(
   input  logic                    RX_CLK,
   input  logic                    rx_rst,
   input  logic                    byte_wr,
   input  logic                    frame_ready,
   input  eth_crc_t                crc_value,
   output logic [`ETH_RX_BUF_AW:0] frame_len,
   output logic                    crc_ok
);

   logic [`ETH_RX_BUF_AW:0] byte_cnt;
   logic [`ETH_RX_BUF_AW:0] len_q;
   logic                    ok_q;
   logic                    ready_q;
   logic [1:0]              wr_hist;
   logic                    ready_rise;
   logic                    crc_match;

   assign ready_rise = frame_ready && !ready_q;
   assign crc_match  = (crc_value == `ETH_CRC_RESIDUE);

   // writes come every second clock inside a frame,
   // so a write without one two clocks before opens a new frame
   always_ff @(posedge RX_CLK or posedge rx_rst) begin
      if (rx_rst) begin
         byte_cnt <= '0;
         len_q    <= '0;
         ok_q     <= 1'b0;
         ready_q  <= 1'b0;
         wr_hist  <= 2'b00;
      end else begin
         ready_q <= frame_ready;
         wr_hist <= {wr_hist[0], byte_wr};

         if (ready_rise) begin
            len_q    <= byte_cnt;
            ok_q     <= crc_match;
            byte_cnt <= '0;
         end else if (byte_wr) begin
            if (wr_hist[1]) begin
               byte_cnt <= byte_cnt + 1'b1;
            end else begin
               byte_cnt <= {{`ETH_RX_BUF_AW{1'b0}}, 1'b1};
            end
         end
      end
   end

   // live values in the first ready cycle, held ones after
   assign frame_len = ready_rise ? byte_cnt : len_q;
   assign crc_ok    = ready_rise ? crc_match : ok_q;

endmodule

// File: hw/eth_rx_top.sv
`timescale 1ns/1ps

`include "eth_rx_config.svh"

module eth_rx_top
   import eth_rx_pkg::*;
(
   input  logic                    RX_CLK,
   input  logic                    rx_rst,
   input  logic                    rx_dv,
   input  logic [3:0]              rx_data,
   input  logic                    frame_ack,
   input  eth_buf_addr_t           rd_addr,
   output logic                    frame_ready,
   output logic [`ETH_RX_BUF_AW:0] frame_len,
   output logic                    crc_ok,
   output eth_byte_t               rd_data
);

   logic          byte_wr;
   eth_buf_addr_t wr_addr;
   eth_byte_t     wr_data;
   eth_crc_t      crc_value;

   eth_rx rx0 (
      .RX_CLK      (RX_CLK),
      .rx_rst      (rx_rst),
      .rx_dv       (rx_dv),
      .rx_data     (rx_data),
      .frame_ack   (frame_ack),
      .frame_ready (frame_ready),
      .byte_wr     (byte_wr),
      .wr_addr     (wr_addr),
      .wr_data     (wr_data),
      .crc_value   (crc_value)
   );

   eth_rx_buffer buffer0 (
      .RX_CLK  (RX_CLK),
      .byte_wr (byte_wr),
      .wr_addr (wr_addr),
      .wr_data (wr_data),
      .rd_addr (rd_addr),
      .rd_data (rd_data)
   );

   // length and crc verdict for the host
   eth_rx_status status0 (
      .RX_CLK      (RX_CLK),
      .rx_rst      (rx_rst),
      .byte_wr     (byte_wr),
      .frame_ready (frame_ready),
      .crc_value   (crc_value),
      .frame_len   (frame_len),
      .crc_ok      (crc_ok)
   );

endmodule

// File: include/eth_rx_config.svh
`ifndef ETH_RX_CONFIG_SVH
`define ETH_RX_CONFIG_SVH

// station address, first byte on the wire is the most significant
`define ETH_MAC_ADDR 48'h02_00_5E_10_20_30

// start of frame delimiter after the 55 preamble bytes
`define ETH_SFD 8'hD5

// destination address bytes compared at frame start
`define ETH_MAC_ADDR_LEN 6

// frame buffer geometry
`define ETH_RX_BUF_AW 11
`define ETH_RX_BUF_DEPTH 2048

// register value left after a good frame and its FCS went through
`define ETH_CRC_RESIDUE 32'hDEBB20E3

`endif

// File: run_sim.sh
#!/bin/sh
# build the MII receive testbench with Verilator, run it and check the verdict
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module eth_rx_tb \
   -f eth_rx.f -o eth_rx_sim || exit 1
out="$(./obj_dir/eth_rx_sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "TEST RESULT: PASS" && exit 0 || exit 1

// File: testbench/eth_rx_tb.sv
`timescale 1ns/1ps

`include "eth_rx_config.svh"

module eth_rx_tb
   import eth_rx_pkg::*;
();

   localparam logic [47:0] src_addr    = 48'h02_11_22_33_44_55;
   localparam int          num_frames  = 10;
   localparam int          watchdog_ns = num_frames * 2 * 220 * 8 * 4;

   logic                    RX_CLK;
   logic                    rx_rst;
   logic                    rx_dv;
   logic [3:0]              rx_data;
   logic                    frame_ack;
   eth_buf_addr_t           rd_addr;
   logic                    frame_ready;
   logic [`ETH_RX_BUF_AW:0] frame_len;
   logic                    crc_ok;
   eth_byte_t               rd_data;

   logic [31:0] rng = 32'd18;
   eth_byte_t   tx_frame[$];
   eth_byte_t   exp_bytes_q[$];
   int          exp_len_q[$];
   logic        exp_ok_q[$];
   int          frames_sent = 0;
   int          frames_done = 0;
   int          checks = 0;
   int          errors = 0;
   // keeps the host from acking while a frame is pushed at a busy receiver
   logic        hold_ack = 1'b0;

   eth_rx_top dut0 (
      .RX_CLK      (RX_CLK),
      .rx_rst      (rx_rst),
      .rx_dv       (rx_dv),
      .rx_data     (rx_data),
      .frame_ack   (frame_ack),
      .rd_addr     (rd_addr),
      .frame_ready (frame_ready),
      .frame_len   (frame_len),
      .crc_ok      (crc_ok),
      .rd_data     (rd_data)
   );

   initial begin
      RX_CLK = 1'b0;
      forever #4 RX_CLK = ~RX_CLK;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // ethernet fcs over the first count bytes of tx_frame with final inversion
   function automatic logic [31:0] crc32_ref(input int count);
      logic [31:0] crc;
      int          i;
      int          b;
      crc = 32'hFFFFFFFF;
      for (i = 0; i < count; i++) begin
         crc = crc ^ {24'h0, tx_frame[i]};
         for (b = 0; b < 8; b++) begin
            crc = crc[0] ? ((crc >> 1) ^ 32'hEDB88320) : (crc >> 1);
         end
      end
      return ~crc;
   endfunction

   task automatic compare_value(input string name, input int got, input int expected);
      checks++;
      assert (got == expected) else begin
         errors++;
         $display("FAILED at %0d ns: %s got 0x%0h expected 0x%0h",
                  $time, name, got, expected);
      end
   endtask

   task automatic require_true(input logic cond, input string what);
      checks++;
      assert (cond) else begin
         errors++;
         $display("ERROR at %0d ns: %s", $time, what);
      end
   endtask

   // dest, source, length field, random payload, fcs low byte first
   task automatic build_frame(input logic [47:0] dest, input logic flip_fcs);
      int          payload_len;
      int          i;
      logic [31:0] fcs;
      rng = xorshift32(rng);
      payload_len = 46 + int'(rng % 32'd155);
      tx_frame.delete();
      for (i = `ETH_MAC_ADDR_LEN - 1; i >= 0; i--) begin
         tx_frame.push_back(dest[8*i +: 8]);
      end
      for (i = 5; i >= 0; i--) begin
         tx_frame.push_back(src_addr[8*i +: 8]);
      end
      tx_frame.push_back(eth_byte_t'(payload_len >> 8));
      tx_frame.push_back(eth_byte_t'(payload_len));
      for (i = 0; i < payload_len; i++) begin
         rng = xorshift32(rng);
         tx_frame.push_back(rng[7:0]);
      end
      fcs = crc32_ref(tx_frame.size());
      for (i = 0; i < 4; i++) begin
         tx_frame.push_back(fcs[8*i +: 8]);
      end
      if (flip_fcs) begin
         tx_frame[tx_frame.size() - 3] = ~tx_frame[tx_frame.size() - 3];
      end
   endtask

   task automatic expect_frame();
      int          n;
      int          i;
      logic [31:0] fcs;
      n = tx_frame.size();
      fcs = {tx_frame[n-1], tx_frame[n-2], tx_frame[n-3], tx_frame[n-4]};
      exp_len_q.push_back(n);
      exp_ok_q.push_back(crc32_ref(n - 4) == fcs);
      for (i = 0; i < n; i++) begin
         exp_bytes_q.push_back(tx_frame[i]);
      end
      frames_sent++;
   endtask

   task automatic send_byte(input eth_byte_t b);
      @(negedge RX_CLK);
      rx_dv   = 1'b1;
      rx_data = b[3:0];
      @(negedge RX_CLK);
      rx_data = b[7:4];
   endtask

   task automatic send_frame(input int preamble_len);
      int i;
      for (i = 0; i < preamble_len; i++) begin
         send_byte(8'h55);
      end
      send_byte(`ETH_SFD);
      for (i = 0; i < tx_frame.size(); i++) begin
         send_byte(tx_frame[i]);
      end
      @(negedge RX_CLK);
      rx_dv   = 1'b0;
      rx_data = 4'h0;
   endtask

   task automatic wait_idle();
      while (frames_done < frames_sent || frame_ready) begin
         @(negedge RX_CLK);
      end
   endtask

   // host side reads each reported frame back and acks it
   initial begin : compare_frames
      int        len;
      logic      ok;
      int        i;
      eth_byte_t want;
      frame_ack = 1'b0;
      rd_addr   = '0;
      forever begin
         @(negedge RX_CLK);
         if (frame_ready) begin
            if (exp_len_q.size() == 0) begin
               require_true(1'b0, "frame_ready raised with no frame outstanding");
            end else begin
               len = exp_len_q.pop_front();
               ok  = exp_ok_q.pop_front();
               compare_value("frame_len", int'(frame_len), len);
               compare_value("crc_ok", int'(crc_ok), int'(ok));
               while (hold_ack) begin
                  @(negedge RX_CLK);
               end
               rd_addr = '0;
               for (i = 0; i < len; i++) begin
                  @(negedge RX_CLK);
                  want = exp_bytes_q.pop_front();
                  if (i + 1 < len) begin
                     rd_addr = eth_buf_addr_t'(i + 1);
                  end
                  compare_value($sformatf("rd_data[%0d]", i), int'(rd_data), int'(want));
               end
               frames_done++;
            end
            frame_ack = 1'b1;
            @(negedge RX_CLK);
            frame_ack = 1'b0;
            while (frame_ready) begin
               @(negedge RX_CLK);
            end
         end
      end
   end

   initial begin : stimulus
      int   i;
      int   n;
      logic seen;
      rx_rst  = 1'b1;
      rx_dv   = 1'b0;
      rx_data = 4'h0;
      repeat (10) @(negedge RX_CLK);
      rx_rst = 1'b0;
      repeat (4) @(negedge RX_CLK);

      compare_value("frame_ready", int'(frame_ready), 0);
      compare_value("frame_len", int'(frame_len), 0);
      compare_value("crc_ok", int'(crc_ok), 0);

      build_frame(`ETH_MAC_ADDR, 1'b0);
      expect_frame();
      send_frame(7);
      wait_idle();

      // corrupted fcs byte
      build_frame(`ETH_MAC_ADDR, 1'b1);
      expect_frame();
      send_frame(7);
      wait_idle();

      // frame to another station and then a good one
      build_frame(`ETH_MAC_ADDR ^ 48'h1, 1'b0);
      send_frame(7);
      n = 4 * tx_frame.size();
      seen = 1'b0;
      for (i = 0; i < n; i++) begin
         @(negedge RX_CLK);
         seen = seen | frame_ready;
      end
      require_true(!seen, "frame_ready raised for a frame to another address");
      build_frame(`ETH_MAC_ADDR, 1'b0);
      expect_frame();
      send_frame(7);
      wait_idle();

      // second frame while the first is still unacknowledged
      hold_ack = 1'b1;
      build_frame(`ETH_MAC_ADDR, 1'b0);
      expect_frame();
      send_frame(7);
      while (!frame_ready) begin
         @(negedge RX_CLK);
      end
      build_frame(`ETH_MAC_ADDR, 1'b0);
      send_frame(7);
      require_true(frame_ready, "frame_ready dropped before frame_ack");
      hold_ack = 1'b0;
      wait_idle();
      build_frame(`ETH_MAC_ADDR, 1'b0);
      expect_frame();
      send_frame(7);
      wait_idle();

      // short, normal and long preambles
      for (i = 0; i < 3; i++) begin
         build_frame(`ETH_MAC_ADDR, 1'b0);
         expect_frame();
         send_frame((i == 0) ? 1 : ((i == 1) ? 7 : 15));
         wait_idle();
      end

      repeat (4) @(negedge RX_CLK);
      $display("checks %0d, errors %0d, frames %0d of %0d received",
               checks, errors, frames_done, frames_sent);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      #(watchdog_ns);
      $display("watchdog expired after %0d ns, receiver or host handshake stuck", watchdog_ns);
      $display("checks %0d, errors %0d, frames %0d of %0d received",
               checks, errors, frames_done, frames_sent);
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule
